// ==== rtl/isa_pkg.sv ====
// RV32IM encodings and decode types shared by the decoder, the immediate
// generator and the issue stage. Instructions match by {match, mask} pairs.
package isa_pkg;

  // linearized opcode handed from decode to issue
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLT, OP_SLTU, OP_SRA, OP_SRL, OP_SLL,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_MUL, OP_LW, OP_SW
  } rv_uop;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } rv_imm_type;

  // one instruction word seen through the base formats
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
  } rv_inst_t;

  // ------------------------------------------------------------------------
  // match and mask pairs, packed as {match, mask}
  // ------------------------------------------------------------------------
  localparam logic [31:0] MASK_R  = 32'hfe00707f;
  localparam logic [31:0] MASK_F3 = 32'h0000707f;
  localparam logic [31:0] MASK_OP = 32'h0000007f;

  // register-register
  localparam logic [63:0] RV_ADD   = {32'h00000033, MASK_R};
  localparam logic [63:0] RV_SUB   = {32'h40000033, MASK_R};
  localparam logic [63:0] RV_SLL   = {32'h00001033, MASK_R};
  localparam logic [63:0] RV_SLT   = {32'h00002033, MASK_R};
  localparam logic [63:0] RV_SLTU  = {32'h00003033, MASK_R};
  localparam logic [63:0] RV_XOR   = {32'h00004033, MASK_R};
  localparam logic [63:0] RV_SRL   = {32'h00005033, MASK_R};
  localparam logic [63:0] RV_SRA   = {32'h40005033, MASK_R};
  localparam logic [63:0] RV_OR    = {32'h00006033, MASK_R};
  localparam logic [63:0] RV_AND   = {32'h00007033, MASK_R};
  localparam logic [63:0] RV_MUL   = {32'h02000033, MASK_R};

  // register-immediate, shifts keep funct7 in the mask
  localparam logic [63:0] RV_ADDI  = {32'h00000013, MASK_F3};
  localparam logic [63:0] RV_SLTI  = {32'h00002013, MASK_F3};
  localparam logic [63:0] RV_SLTIU = {32'h00003013, MASK_F3};
  localparam logic [63:0] RV_XORI  = {32'h00004013, MASK_F3};
  localparam logic [63:0] RV_ORI   = {32'h00006013, MASK_F3};
  localparam logic [63:0] RV_ANDI  = {32'h00007013, MASK_F3};
  localparam logic [63:0] RV_SLLI  = {32'h00001013, MASK_R};
  localparam logic [63:0] RV_SRLI  = {32'h00005013, MASK_R};
  localparam logic [63:0] RV_SRAI  = {32'h40005013, MASK_R};
  localparam logic [63:0] RV_LUI   = {32'h00000037, MASK_OP};
  localparam logic [63:0] RV_AUIPC = {32'h00000017, MASK_OP};

  // memory
  localparam logic [63:0] RV_LW    = {32'h00002003, MASK_F3};
  localparam logic [63:0] RV_SW    = {32'h00002023, MASK_F3};

  // control flow
  localparam logic [63:0] RV_JAL   = {32'h0000006f, MASK_OP};
  localparam logic [63:0] RV_JALR  = {32'h00000067, MASK_F3};
  localparam logic [63:0] RV_BEQ   = {32'h00000063, MASK_F3};
  localparam logic [63:0] RV_BNE   = {32'h00001063, MASK_F3};
  localparam logic [63:0] RV_BLT   = {32'h00004063, MASK_F3};
  localparam logic [63:0] RV_BGE   = {32'h00005063, MASK_F3};
  localparam logic [63:0] RV_BLTU  = {32'h00006063, MASK_F3};
  localparam logic [63:0] RV_BGEU  = {32'h00007063, MASK_F3};

endpackage

// ==== rtl/uarch_pkg.sv ====
// Micro-architecture codes of the decode and issue stage.
// Jump kind, operand selects and register address width.
package uarch_pkg;

  localparam int REG_ADDR_W = 5;

  typedef enum logic [1:0] {
    J_NONE,
    J_JAL,
    J_JALR
  } jump_t;

  // second operand source
  typedef enum logic {
    OP2_RF,
    OP2_IMM
  } op2_sel_t;

  // third operand use, memory access or branch compare
  typedef enum logic {
    OP3_MEM,
    OP3_BR
  } op3_sel_t;

endpackage

// ==== rtl/decode_if.sv ====
// Decoded control from the instruction decoder to the issue stage.
`timescale 1ns/100ps

interface decode_if;

  logic                                val;
  isa_pkg::rv_uop                      uop;
  uarch_pkg::jump_t                    jal;
  logic [uarch_pkg::REG_ADDR_W-1:0]    raddr0;
  logic [uarch_pkg::REG_ADDR_W-1:0]    raddr1;
  logic [uarch_pkg::REG_ADDR_W-1:0]    waddr;
  logic                                wen;
  isa_pkg::rv_imm_type                 imm_sel;
  uarch_pkg::op2_sel_t                 op2_sel;
  uarch_pkg::op3_sel_t                 op3_sel;

  modport decoder_mp (
    output val, uop, jal, raddr0, raddr1, waddr, wen, imm_sel, op2_sel, op3_sel
  );

  modport issue_mp (
    input val, uop, jal, raddr0, raddr1, waddr, wen, imm_sel, op2_sel, op3_sel
  );

endinterface

// ==== rtl/inst_decoder.sv ====
// Combinational RV32IM decoder. Maps one instruction word to a linear
// micro-op and the control fields the issue stage needs.
`timescale 1ns/100ps

module inst_decoder (
  input  isa_pkg::rv_inst_t inst,
  decode_if.decoder_mp      dec
);

  // ------------------------------------------------------------------------
  // short names for the table columns
  // ------------------------------------------------------------------------
  localparam logic Y = 1'b1;
  localparam logic N = 1'b0;

  // unused register, never stalls
  localparam logic [uarch_pkg::REG_ADDR_W-1:0] RX = '0;

  localparam uarch_pkg::jump_t    J_N    = uarch_pkg::J_NONE;
  localparam uarch_pkg::jump_t    J_JAL  = uarch_pkg::J_JAL;
  localparam uarch_pkg::jump_t    J_JALR = uarch_pkg::J_JALR;
  localparam uarch_pkg::op2_sel_t RF     = uarch_pkg::OP2_RF;
  localparam uarch_pkg::op2_sel_t IMM    = uarch_pkg::OP2_IMM;
  localparam uarch_pkg::op3_sel_t MEM    = uarch_pkg::OP3_MEM;
  localparam uarch_pkg::op3_sel_t BR     = uarch_pkg::OP3_BR;

  localparam isa_pkg::rv_imm_type IMM_I = isa_pkg::IMM_I;
  localparam isa_pkg::rv_imm_type IMM_S = isa_pkg::IMM_S;
  localparam isa_pkg::rv_imm_type IMM_B = isa_pkg::IMM_B;
  localparam isa_pkg::rv_imm_type IMM_U = isa_pkg::IMM_U;
  localparam isa_pkg::rv_imm_type IMM_J = isa_pkg::IMM_J;

  logic [uarch_pkg::REG_ADDR_W-1:0] rs1;
  logic [uarch_pkg::REG_ADDR_W-1:0] rs2;
  logic [uarch_pkg::REG_ADDR_W-1:0] rd;

  assign rs1 = inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;
  assign rd  = inst.r_fmt.rd;

  // masked word equals match
  function automatic logic hit(input logic [63:0] pat);
    return (inst & pat[31:0]) == pat[63:32];
  endfunction

  task automatic cs(
    input logic                             c_val,
    input isa_pkg::rv_uop                   c_uop,
    input uarch_pkg::jump_t                 c_jal,
    input logic [uarch_pkg::REG_ADDR_W-1:0] c_raddr0,
    input logic [uarch_pkg::REG_ADDR_W-1:0] c_raddr1,
    input logic [uarch_pkg::REG_ADDR_W-1:0] c_waddr,
    input logic                             c_wen,
    input isa_pkg::rv_imm_type              c_imm_sel,
    input uarch_pkg::op2_sel_t              c_op2_sel,
    input uarch_pkg::op3_sel_t              c_op3_sel
  );
    dec.val     = c_val;
    dec.uop     = c_uop;
    dec.jal     = c_jal;
    dec.raddr0  = c_raddr0;
    dec.raddr1  = c_raddr1;
    dec.waddr   = c_waddr;
    dec.wen     = c_wen;
    dec.imm_sel = c_imm_sel;
    dec.op2_sel = c_op2_sel;
    dec.op3_sel = c_op3_sel;
  endtask

  // ------------------------------------------------------------------------
  // control table
  // ------------------------------------------------------------------------
  always_comb begin
    casez (1'b1) //                  uop             jal     rs1  rs2  rd  wen imm    op2  op3
      hit(isa_pkg::RV_ADD):   cs(Y, isa_pkg::OP_ADD,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_SUB):   cs(Y, isa_pkg::OP_SUB,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_AND):   cs(Y, isa_pkg::OP_AND,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_OR):    cs(Y, isa_pkg::OP_OR,    J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_XOR):   cs(Y, isa_pkg::OP_XOR,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_SLT):   cs(Y, isa_pkg::OP_SLT,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_SLTU):  cs(Y, isa_pkg::OP_SLTU,  J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_SRA):   cs(Y, isa_pkg::OP_SRA,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_SRL):   cs(Y, isa_pkg::OP_SRL,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_SLL):   cs(Y, isa_pkg::OP_SLL,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_MUL):   cs(Y, isa_pkg::OP_MUL,   J_N,    rs1, rs2, rd, Y, IMM_I, RF,  MEM);

      hit(isa_pkg::RV_ADDI):  cs(Y, isa_pkg::OP_ADD,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_ANDI):  cs(Y, isa_pkg::OP_AND,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_ORI):   cs(Y, isa_pkg::OP_OR,    J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_XORI):  cs(Y, isa_pkg::OP_XOR,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_SLTI):  cs(Y, isa_pkg::OP_SLT,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_SLTIU): cs(Y, isa_pkg::OP_SLTU,  J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_SRAI):  cs(Y, isa_pkg::OP_SRA,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_SRLI):  cs(Y, isa_pkg::OP_SRL,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_SLLI):  cs(Y, isa_pkg::OP_SLL,   J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_LUI):   cs(Y, isa_pkg::OP_LUI,   J_N,    RX,  RX,  rd, Y, IMM_U, IMM, MEM);
      hit(isa_pkg::RV_AUIPC): cs(Y, isa_pkg::OP_AUIPC, J_N,    RX,  RX,  rd, Y, IMM_U, IMM, MEM);

      hit(isa_pkg::RV_LW):    cs(Y, isa_pkg::OP_LW,    J_N,    rs1, RX,  rd, Y, IMM_I, IMM, MEM);
      hit(isa_pkg::RV_SW):    cs(Y, isa_pkg::OP_SW,    J_N,    rs1, rs2, RX, N, IMM_S, IMM, MEM);

      hit(isa_pkg::RV_JAL):   cs(Y, isa_pkg::OP_JAL,   J_JAL,  RX,  RX,  rd, Y, IMM_J, RF,  MEM);
      hit(isa_pkg::RV_JALR):  cs(Y, isa_pkg::OP_JALR,  J_JALR, rs1, RX,  rd, Y, IMM_I, RF,  MEM);
      hit(isa_pkg::RV_BEQ):   cs(Y, isa_pkg::OP_BEQ,   J_N,    rs1, rs2, RX, N, IMM_B, RF,  BR);
      hit(isa_pkg::RV_BNE):   cs(Y, isa_pkg::OP_BNE,   J_N,    rs1, rs2, RX, N, IMM_B, RF,  BR);
      hit(isa_pkg::RV_BLT):   cs(Y, isa_pkg::OP_BLT,   J_N,    rs1, rs2, RX, N, IMM_B, RF,  BR);
      hit(isa_pkg::RV_BGE):   cs(Y, isa_pkg::OP_BGE,   J_N,    rs1, rs2, RX, N, IMM_B, RF,  BR);
      hit(isa_pkg::RV_BLTU):  cs(Y, isa_pkg::OP_BLTU,  J_N,    rs1, rs2, RX, N, IMM_B, RF,  BR);
      hit(isa_pkg::RV_BGEU):  cs(Y, isa_pkg::OP_BGEU,  J_N,    rs1, rs2, RX, N, IMM_B, RF,  BR);
      // illegal, including CSR, fence, ecall and compressed words
      default:                cs(N, isa_pkg::OP_ADD,   J_N,    RX,  RX,  RX, N, IMM_I, RF,  MEM);
    endcase
  end

endmodule

// ==== rtl/imm_gen.sv ====
// Immediate generator. Assembles the I, S, B, U or J immediate of an
// instruction and sign-extends it to the operand width.
`timescale 1ns/100ps

module imm_gen #(
  parameter int XLEN = 32
) (
  input  isa_pkg::rv_inst_t   inst,
  input  isa_pkg::rv_imm_type imm_sel,
  output logic [XLEN-1:0]     imm
);

  logic signed [31:0] imm32;

  always_comb begin
    case (imm_sel)
      isa_pkg::IMM_I: imm32 = 32'($signed(inst.i_fmt.imm12));
      isa_pkg::IMM_S: imm32 = 32'($signed({inst.s_fmt.imm_hi, inst.s_fmt.imm_lo}));
      // branch offset scattered over the store fields
      isa_pkg::IMM_B: imm32 = 32'($signed({inst.s_fmt.imm_hi[6], inst.s_fmt.imm_lo[0],
                                           inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1],
                                           1'b0}));
      isa_pkg::IMM_U: imm32 = {inst.i_fmt.imm12, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'b0};
      // jump offset, bits 19:12 sit in rs1 and funct3
      isa_pkg::IMM_J: imm32 = 32'($signed({inst.i_fmt.imm12[11], inst.i_fmt.rs1,
                                           inst.i_fmt.funct3, inst.i_fmt.imm12[0],
                                           inst.i_fmt.imm12[10:1], 1'b0}));
      default:        imm32 = '0;
    endcase
  end

  // further sign extension for wider operands
  assign imm = XLEN'(imm32);

endmodule

// ==== rtl/reg_file.sv ====
// Integer register file. 32 entries, two combinational read ports and
// one write port, x0 reads as zero.
`timescale 1ns/100ps

module reg_file #(
  parameter int XLEN = 32
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [uarch_pkg::REG_ADDR_W-1:0] raddr0,
  input  logic [uarch_pkg::REG_ADDR_W-1:0] raddr1,
  output logic [XLEN-1:0]                  rdata0,
  output logic [XLEN-1:0]                  rdata1,
  input  logic                             wen,
  input  logic [uarch_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [XLEN-1:0]                  wdata
);

  localparam int NREGS = 1 << uarch_pkg::REG_ADDR_W;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NREGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// ==== rtl/issue_stage.sv ====
// Issue stage. Tracks pending destinations in a scoreboard, stalls fetch
// on a hazard and registers one issue packet per accepted instruction.
`timescale 1ns/100ps

module issue_stage #(
  parameter int XLEN = 32
) (
  input  logic                             clk,
  input  logic                             rst_n,
  decode_if.issue_mp                       dec,
  input  logic                             inst_val,
  input  logic [XLEN-1:0]                  imm,
  input  logic [XLEN-1:0]                  rdata0,
  input  logic [XLEN-1:0]                  rdata1,
  input  logic                             wb_en,
  input  logic [uarch_pkg::REG_ADDR_W-1:0] wb_addr,
  output logic                             stall,
  output logic                             iss_val,
  output isa_pkg::rv_uop                   iss_uop,
  output uarch_pkg::jump_t                 iss_jal,
  output uarch_pkg::op3_sel_t              iss_op3_sel,
  output logic [uarch_pkg::REG_ADDR_W-1:0] iss_waddr,
  output logic                             iss_wen,
  output logic [XLEN-1:0]                  iss_op1,
  output logic [XLEN-1:0]                  iss_op2,
  output logic [XLEN-1:0]                  iss_store_data,
  output logic [XLEN-1:0]                  iss_imm,
  output logic                             illegal
);

  localparam int NREGS = 1 << uarch_pkg::REG_ADDR_W;

  logic [NREGS-1:0] pending;
  logic [NREGS-1:0] use_mask;
  logic [NREGS-1:0] set_mask;
  logic [NREGS-1:0] clr_mask;
  logic             accept;
  logic             issue;

  // ------------------------------------------------------------------------
  // scoreboard and stall
  // ------------------------------------------------------------------------

  // bit 0 is never pending, so unused fields at x0 never stall
  assign use_mask = (NREGS'(1) << dec.raddr0) | (NREGS'(1) << dec.raddr1)
                  | (NREGS'(1) << dec.waddr);

  // RAW on a source or WAW on the destination
  assign stall  = inst_val && dec.val && |(pending & use_mask);
  assign accept = inst_val && !stall;
  assign issue  = accept && dec.val;

  assign set_mask = (issue && dec.wen && dec.waddr != '0) ? NREGS'(1) << dec.waddr : '0;
  assign clr_mask = wb_en ? NREGS'(1) << wb_addr : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
      iss_val <= 1'b0;
      illegal <= 1'b0;
    end else begin
      // a new issue wins over a writeback to the same register
      pending <= (pending & ~clr_mask) | set_mask;
      iss_val <= issue;
      illegal <= accept && !dec.val;
    end
  end

  // ------------------------------------------------------------------------
  // issue packet
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (issue) begin
      iss_uop        <= dec.uop;
      iss_jal        <= dec.jal;
      iss_op3_sel    <= dec.op3_sel;
      iss_waddr      <= dec.waddr;
      iss_wen        <= dec.wen;
      iss_op1        <= rdata0;
      iss_op2        <= (dec.op2_sel == uarch_pkg::OP2_IMM) ? imm : rdata1;
      iss_store_data <= rdata1;
      iss_imm        <= imm;
    end
  end

endmodule

// ==== rtl/decode_issue.sv ====
// Decode and issue stage of a small in-order RV32IM core.
// Takes a fetched word with a valid level, writeback on plain ports,
// and issues one registered packet per accepted instruction.
`timescale 1ns/100ps

module decode_issue #(
  parameter int XLEN = 32
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             inst_val,
  input  logic [31:0]                      inst,
  output logic                             stall,
  input  logic                             wb_en,
  input  logic [uarch_pkg::REG_ADDR_W-1:0] wb_addr,
  input  logic [XLEN-1:0]                  wb_data,
  output logic                             iss_val,
  output isa_pkg::rv_uop                   iss_uop,
  output uarch_pkg::jump_t                 iss_jal,
  output uarch_pkg::op3_sel_t              iss_op3_sel,
  output logic [uarch_pkg::REG_ADDR_W-1:0] iss_waddr,
  output logic                             iss_wen,
  output logic [XLEN-1:0]                  iss_op1,
  output logic [XLEN-1:0]                  iss_op2,
  output logic [XLEN-1:0]                  iss_store_data,
  output logic [XLEN-1:0]                  iss_imm,
  output logic                             illegal
);

  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rdata0;
  logic [XLEN-1:0] rdata1;

  decode_if dec_bus ();

  inst_decoder inst_decoder_inst (
    .inst (inst),
    .dec  (dec_bus)
  );

  imm_gen #(.XLEN(XLEN)) imm_gen_inst (
    .inst    (inst),
    .imm_sel (dec_bus.imm_sel),
    .imm     (imm)
  );

  // read ports follow the decoded addresses directly
  reg_file #(.XLEN(XLEN)) reg_file_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (dec_bus.raddr0),
    .raddr1 (dec_bus.raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (wb_en),
    .waddr  (wb_addr),
    .wdata  (wb_data)
  );

  issue_stage #(.XLEN(XLEN)) issue_stage_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .dec            (dec_bus),
    .inst_val       (inst_val),
    .imm            (imm),
    .rdata0         (rdata0),
    .rdata1         (rdata1),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .stall          (stall),
    .iss_val        (iss_val),
    .iss_uop        (iss_uop),
    .iss_jal        (iss_jal),
    .iss_op3_sel    (iss_op3_sel),
    .iss_waddr      (iss_waddr),
    .iss_wen        (iss_wen),
    .iss_op1        (iss_op1),
    .iss_op2        (iss_op2),
    .iss_store_data (iss_store_data),
    .iss_imm        (iss_imm),
    .illegal        (illegal)
  );

endmodule

// ==== bench/decode_model.svh ====
// Reference model of the decode and issue stage, included in the testbench
// module. Decodes by {match, mask} rows, holds registers and pending bits.
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

localparam int NPAT = 32;

// legal instructions and their micro-ops, row by row
localparam logic [63:0] PAT_TAB [NPAT] = '{
  isa_pkg::RV_ADD, isa_pkg::RV_SUB, isa_pkg::RV_SLL, isa_pkg::RV_SLT, isa_pkg::RV_SLTU,
  isa_pkg::RV_XOR, isa_pkg::RV_SRL, isa_pkg::RV_SRA, isa_pkg::RV_OR, isa_pkg::RV_AND,
  isa_pkg::RV_MUL, isa_pkg::RV_ADDI, isa_pkg::RV_SLTI, isa_pkg::RV_SLTIU, isa_pkg::RV_XORI,
  isa_pkg::RV_ORI, isa_pkg::RV_ANDI, isa_pkg::RV_SLLI, isa_pkg::RV_SRLI, isa_pkg::RV_SRAI,
  isa_pkg::RV_LW, isa_pkg::RV_LUI, isa_pkg::RV_AUIPC, isa_pkg::RV_SW, isa_pkg::RV_JAL,
  isa_pkg::RV_JALR, isa_pkg::RV_BEQ, isa_pkg::RV_BNE, isa_pkg::RV_BLT, isa_pkg::RV_BGE,
  isa_pkg::RV_BLTU, isa_pkg::RV_BGEU
};
localparam isa_pkg::rv_uop UOP_TAB [NPAT] = '{
  isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_SLL, isa_pkg::OP_SLT, isa_pkg::OP_SLTU,
  isa_pkg::OP_XOR, isa_pkg::OP_SRL, isa_pkg::OP_SRA, isa_pkg::OP_OR, isa_pkg::OP_AND,
  isa_pkg::OP_MUL, isa_pkg::OP_ADD, isa_pkg::OP_SLT, isa_pkg::OP_SLTU, isa_pkg::OP_XOR,
  isa_pkg::OP_OR, isa_pkg::OP_AND, isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA,
  isa_pkg::OP_LW, isa_pkg::OP_LUI, isa_pkg::OP_AUIPC, isa_pkg::OP_SW, isa_pkg::OP_JAL,
  isa_pkg::OP_JALR, isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BLT, isa_pkg::OP_BGE,
  isa_pkg::OP_BLTU, isa_pkg::OP_BGEU
};

logic [XLEN-1:0]     m_regs [32];
logic [31:0]         m_pend;
logic                m_val;
isa_pkg::rv_uop      m_uop;
uarch_pkg::jump_t    m_jal;
uarch_pkg::op3_sel_t m_op3;
// operand use as {rs1, rs2, rd, immediate operand}
logic [3:0]          m_use;
logic [4:0]          m_rs1;
logic [4:0]          m_rs2;
logic [4:0]          m_rd;

task automatic model_decode(input logic [31:0] w);
  m_val = 1'b0;
  m_uop = isa_pkg::OP_ADD;
  for (int i = 0; i < NPAT; i++) begin
    if (!m_val && (w & PAT_TAB[i][31:0]) == PAT_TAB[i][63:32]) begin
      m_val = 1'b1;
      m_uop = UOP_TAB[i];
    end
  end
  // operand use follows the major opcode
  case (w[6:0])
    7'h33:        m_use = 4'b1110;
    7'h13, 7'h03: m_use = 4'b1011;
    7'h37, 7'h17: m_use = 4'b0011;
    7'h23:        m_use = 4'b1101;
    7'h6f:        m_use = 4'b0010;
    7'h67:        m_use = 4'b1010;
    default:      m_use = 4'b1100;
  endcase
  if (!m_val)
    m_use = 4'b0000;
  m_jal = (w[6:0] == 7'h6f) ? uarch_pkg::J_JAL :
          (w[6:0] == 7'h67) ? uarch_pkg::J_JALR : uarch_pkg::J_NONE;
  m_op3 = (w[6:0] == 7'h63) ? uarch_pkg::OP3_BR : uarch_pkg::OP3_MEM;
  // unused register fields read as x0
  m_rs1 = m_use[3] ? w[19:15] : 5'd0;
  m_rs2 = m_use[2] ? w[24:20] : 5'd0;
  m_rd  = m_use[1] ? w[11:7] : 5'd0;
endtask

// immediate formats of the base ISA
function automatic logic [XLEN-1:0] model_imm(input logic [31:0] w);
  logic [31:0] v;
  case (w[6:0])
    7'h23:        v = {{21{w[31]}}, w[30:25], w[11:7]};
    7'h63:        v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    7'h37, 7'h17: v = {w[31:12], 12'h000};
    7'h6f:        v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    default:      v = {{21{w[31]}}, w[30:20]};
  endcase
  return XLEN'($signed(v));
endfunction

// RAW on a source or WAW on the destination
function automatic logic model_stall(input logic v);
  return v && m_val && ((m_rs1 != 5'd0 && m_pend[m_rs1]) ||
         (m_rs2 != 5'd0 && m_pend[m_rs2]) || (m_rd != 5'd0 && m_pend[m_rd]));
endfunction

// one clock edge, an issue sets its bit after the writeback clear
task automatic model_edge(input logic issue, input logic wb, input logic [4:0] wa,
                          input logic [XLEN-1:0] wd);
  if (wb) begin
    m_pend[wa] = 1'b0;
    if (wa != 5'd0)
      m_regs[wa] = wd;
  end
  if (issue && m_use[1] && m_rd != 5'd0)
    m_pend[m_rd] = 1'b1;
endtask

`endif

// ==== bench/tb_decode_issue.sv ====
// Testbench of the decode and issue stage. Drives random legal and illegal
// words with random writebacks and checks every cycle against the model.
`timescale 1ns/100ps

module tb_decode_issue;

  localparam int XLEN   = 32;
  localparam int N_INST = 400;
  localparam int PERIOD = 40;

  logic                clk;
  logic                rst_n;
  logic                inst_val;
  logic [31:0]         inst;
  logic                stall;
  logic                wb_en;
  logic [4:0]          wb_addr;
  logic [XLEN-1:0]     wb_data;
  logic                iss_val;
  isa_pkg::rv_uop      iss_uop;
  uarch_pkg::jump_t    iss_jal;
  uarch_pkg::op3_sel_t iss_op3_sel;
  logic [4:0]          iss_waddr;
  logic                iss_wen;
  logic [XLEN-1:0]     iss_op1;
  logic [XLEN-1:0]     iss_op2;
  logic [XLEN-1:0]     iss_store_data;
  logic [XLEN-1:0]     iss_imm;
  logic                illegal;

  `include "decode_model.svh"

  int              n_checks;
  int              n_errors;
  int              n_done;
  logic            held;
  logic            stall_exp;
  logic            issue;
  // packet expected after the next edge
  logic            e_iss;
  logic            e_ill;
  logic [31:0]     e_word;
  logic [XLEN-1:0] e_op1;
  logic [XLEN-1:0] e_sd;

  decode_issue #(.XLEN(XLEN)) decode_issue_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [XLEN-1:0] imm_exp;
    check_eq(iss_val, e_iss, "iss_val");
    check_eq(illegal, e_ill, "illegal");
    if (e_iss) begin
      model_decode(e_word);
      imm_exp = model_imm(e_word);
      check_eq(iss_uop, m_uop, "iss_uop");
      check_eq(iss_jal, m_jal, "iss_jal");
      check_eq(iss_op3_sel, m_op3, "iss_op3_sel");
      check_eq(iss_waddr, m_rd, "iss_waddr");
      check_eq(iss_wen, m_use[1], "iss_wen");
      check_eq(iss_op1, e_op1, "iss_op1");
      check_eq(iss_store_data, e_sd, "iss_store_data");
      check_eq(iss_op2, m_use[0] ? imm_exp : e_sd, "iss_op2");
      // register-register words carry no immediate
      if (e_word[6:0] != 7'h33)
        check_eq(iss_imm, imm_exp, "iss_imm");
    end
  endtask

  // ------------------------------------------------------------------------
  // stimulus where fetch holds its word while stalled
  // ------------------------------------------------------------------------
  task automatic drive_inputs();
    int k;
    k = $urandom % NPAT;
    if (!held) begin
      inst_val = (n_done < 16) || ($urandom % 4 != 0);
      // first reads sweep every register straight after reset
      if (n_done < 16)
        inst = isa_pkg::RV_ADD[63:32] | (32'(2 * n_done) << 15) | (32'(2 * n_done + 1) << 20);
      else if ($urandom % 4 != 0)
        inst = ($urandom & ~PAT_TAB[k][31:0]) | PAT_TAB[k][63:32];
      else
        inst = $urandom;
    end
    wb_en   = (n_done >= 16) && ($urandom % 2 == 0);
    wb_addr = 5'($urandom);
    wb_data = $urandom;
    // mostly retire a pending register
    if (m_pend != 0 && $urandom % 4 != 0) begin
      while (!m_pend[wb_addr])
        wb_addr = wb_addr + 5'd1;
    end
  endtask

  initial begin
    void'($urandom(32'hddcaea57));
    rst_n    = 1'b0;
    // a legal word waits at the input while reset holds the stage idle
    inst_val = 1'b1;
    inst     = isa_pkg::RV_ADDI[63:32] | (32'd1 << 7);
    wb_en    = 1'b0;
    wb_addr  = '0;
    wb_data  = '0;
    n_checks = 0;
    n_errors = 0;
    n_done   = 0;
    held     = 1'b0;
    e_iss    = 1'b0;
    e_ill    = 1'b0;
    m_pend   = '0;
    for (int r = 0; r < 32; r++)
      m_regs[r] = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_eq(iss_val, 1'b0, "iss_val in reset");
    check_eq(illegal, 1'b0, "illegal in reset");
    check_eq(stall, 1'b0, "stall in reset");
    inst_val = 1'b0;
    rst_n    = 1'b1;
    while (n_done < N_INST) begin
      @(negedge clk);
      check_outputs();
      drive_inputs();
      #1;
      model_decode(inst);
      stall_exp = model_stall(inst_val);
      check_eq(stall, stall_exp, "stall");
      held  = stall_exp;
      issue = inst_val && !stall_exp && m_val;
      e_iss = issue;
      e_ill = inst_val && !stall_exp && !m_val;
      if (inst_val && !stall_exp)
        n_done++;
      if (issue) begin
        e_word = inst;
        e_op1  = m_regs[m_rs1];
        e_sd   = m_regs[m_rs2];
      end
      model_edge(issue, wb_en, wb_addr, wb_data);
    end
    @(negedge clk);
    check_outputs();
    $display("instructions %0d, checks %0d, errors %0d", n_done, n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog allows 20 cycles per instruction plus reset
  initial begin
    #((N_INST * 20 + 10) * PERIOD);
    $display("timeout, the stage stopped accepting instructions");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+bench
rtl/isa_pkg.sv
rtl/uarch_pkg.sv
rtl/decode_if.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/issue_stage.sv
rtl/decode_issue.sv
bench/tb_decode_issue.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_decode_issue -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation did not run to completion"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
